//--- Bender.yml
package:
  name: cpuCore

sources:
  - include_dirs:
      - logic
    files:
      - logic/cpuPkg.sv
      - logic/regFile.sv
      - logic/instrDecoder.sv
      - logic/alu.sv
      - logic/hazardUnit.sv
      - logic/datapath.sv
      - logic/cpuCore.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/cpuCoreTb.sv

//--- cpuCore.f
+incdir+logic
+incdir+sim
logic/cpuPkg.sv
logic/regFile.sv
logic/instrDecoder.sv
logic/alu.sv
logic/hazardUnit.sv
logic/datapath.sv
logic/cpuCore.sv
sim/cpuCoreTb.sv

//--- logic/alu.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_settings.svh"

module alu (
    input  wire cpuPkg::opcodeT opcode,
    input  wire cpuPkg::funcT   func,
    input  wire                 isAlu,
    input  wire cpuPkg::wordT   a,
    input  wire cpuPkg::wordT   b,
    output cpuPkg::wordT        result,
    output logic                bcond
);

    cpuPkg::aluOpT op;

    always_comb begin
        if (isAlu) begin
            case (func)
                `FUNC_ADD: op = cpuPkg::aluAdd;
                `FUNC_SUB: op = cpuPkg::aluSub;
                `FUNC_AND: op = cpuPkg::aluAnd;
                `FUNC_ORR: op = cpuPkg::aluOr;
                `FUNC_NOT: op = cpuPkg::aluNot;
                `FUNC_TCP: op = cpuPkg::aluTcp;
                `FUNC_SHL: op = cpuPkg::aluShl;
                `FUNC_SHR: op = cpuPkg::aluShr;
                default:   op = cpuPkg::aluPass;
            endcase
        end else begin
            case (opcode)
                `ADI_OP, `LWD_OP, `SWD_OP:           op = cpuPkg::aluAdd;
                `ORI_OP:                             op = cpuPkg::aluOr;
                `BNE_OP, `BEQ_OP, `BGZ_OP, `BLZ_OP: op = cpuPkg::aluSub;
                // wwd, jumps and links just pass the a operand
                default:                             op = cpuPkg::aluPass;
            endcase
        end
    end

    always_comb begin
        case (op)
            cpuPkg::aluAdd: result = a + b;
            cpuPkg::aluSub: result = a - b;
            cpuPkg::aluAnd: result = a & b;
            cpuPkg::aluOr:  result = a | b;
            cpuPkg::aluNot: result = ~a;
            cpuPkg::aluTcp: result = ~a + `WORD_SIZE'd1;
            cpuPkg::aluShl: result = {a[`WORD_SIZE-2:0], 1'b0};
            cpuPkg::aluShr: result = {a[`WORD_SIZE-1], a[`WORD_SIZE-1:1]};
            default:        result = a;
        endcase
        // lhi moves the immediate into the upper byte
        if (opcode == `LHI_OP) begin
            result = {b[`WORD_SIZE/2-1:0], {(`WORD_SIZE/2){1'b0}}};
        end
    end

    always_comb begin
        case (opcode)
            `BNE_OP: bcond = (a != b);
            `BEQ_OP: bcond = (a == b);
            `BGZ_OP: bcond = !a[`WORD_SIZE-1] && (a != '0);
            `BLZ_OP: bcond = a[`WORD_SIZE-1];
            default: bcond = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

//--- logic/cpuCore.sv
`timescale 1ns/1ps
`default_nettype none

module cpuCore (
    input  wire               Clk,
    input  wire               arstN,
    output cpuPkg::wordT      instrAddr,
    input  wire cpuPkg::wordT instrData,
    output cpuPkg::wordT      dataAddr,
    output cpuPkg::wordT      writeData,
    output logic              dataRead,
    output logic              dataWrite,
    input  wire cpuPkg::wordT readData,
    output cpuPkg::wordT      outputPort,
    output logic              wwdStrobe,
    output cpuPkg::wordT      numInst,
    output logic              halted
);

    cpuPkg::wordT ifIdInstr;
    logic regDst, isJumpI, isJumpR, isAlu, aluSrc, isBranch;
    logic memRead, memWrite, memToReg, regWrite, isWwd;

    // control is decoded from the instruction held in the decode stage
    instrDecoder instrDecoder_i (
        .instr    (ifIdInstr),
        .regDst   (regDst),
        .isJumpI  (isJumpI),
        .isJumpR  (isJumpR),
        .isAlu    (isAlu),
        .aluSrc   (aluSrc),
        .isBranch (isBranch),
        .memRead  (memRead),
        .memWrite (memWrite),
        .memToReg (memToReg),
        .regWrite (regWrite),
        .isWwd    (isWwd)
    );

    datapath datapath_i (
        .Clk        (Clk),
        .arstN      (arstN),
        .instrAddr  (instrAddr),
        .instrData  (instrData),
        .dataAddr   (dataAddr),
        .writeData  (writeData),
        .dataRead   (dataRead),
        .dataWrite  (dataWrite),
        .readData   (readData),
        .ifIdInstr  (ifIdInstr),
        .regDst     (regDst),
        .isJumpI    (isJumpI),
        .isJumpR    (isJumpR),
        .isAlu      (isAlu),
        .aluSrc     (aluSrc),
        .isBranch   (isBranch),
        .memRead    (memRead),
        .memWrite   (memWrite),
        .memToReg   (memToReg),
        .regWrite   (regWrite),
        .isWwd      (isWwd),
        .outputPort (outputPort),
        .wwdStrobe  (wwdStrobe),
        .numInst    (numInst),
        .halted     (halted)
    );

endmodule

`default_nettype wire

//--- logic/cpuPkg.sv
`default_nettype none
`include "cpu_settings.svh"

package cpuPkg;

    // one machine word, data or address
    typedef logic [`WORD_SIZE-1:0] wordT;

    typedef logic [$clog2(`NUM_REGS)-1:0] regIdxT;

    typedef logic [3:0] opcodeT;

    typedef logic [5:0] funcT;

    // where an execute operand comes from
    typedef logic [1:0] fwdSelT;

    localparam fwdSelT fwdNone = 2'd0;
    localparam fwdSelT fwdMem  = 2'd1;
    localparam fwdSelT fwdWb   = 2'd2;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluNot,
        aluTcp,
        aluShl,
        aluShr,
        aluPass
    } aluOpT;

endpackage

`default_nettype wire

//--- logic/cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// machine word width, also used for addresses
`define WORD_SIZE 16
`define NUM_REGS  4

// major opcode in the top four bits
`define BNE_OP   4'd0
`define BEQ_OP   4'd1
`define BGZ_OP   4'd2
`define BLZ_OP   4'd3
`define ADI_OP   4'd4
`define ORI_OP   4'd5
`define LHI_OP   4'd6
`define LWD_OP   4'd7
`define SWD_OP   4'd8
`define JMP_OP   4'd9
`define JAL_OP   4'd10
`define RTYPE_OP 4'd15

// function field of register-type instructions
`define FUNC_ADD 6'd0
`define FUNC_SUB 6'd1
`define FUNC_AND 6'd2
`define FUNC_ORR 6'd3
`define FUNC_NOT 6'd4
`define FUNC_TCP 6'd5
`define FUNC_SHL 6'd6
`define FUNC_SHR 6'd7
`define FUNC_JPR 6'd25
`define FUNC_JRL 6'd26
`define FUNC_WWD 6'd28
`define FUNC_HLT 6'd29

`define DMEM_DEPTH 256

`endif

//--- logic/datapath.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_settings.svh"

module datapath (
    input  wire               Clk,
    input  wire               arstN,
    output cpuPkg::wordT      instrAddr,
    input  wire cpuPkg::wordT instrData,
    output cpuPkg::wordT      dataAddr,
    output cpuPkg::wordT      writeData,
    output logic              dataRead,
    output logic              dataWrite,
    input  wire cpuPkg::wordT readData,
    output cpuPkg::wordT      ifIdInstr,
    input  wire               regDst,
    input  wire               isJumpI,
    input  wire               isJumpR,
    input  wire               isAlu,
    input  wire               aluSrc,
    input  wire               isBranch,
    input  wire               memRead,
    input  wire               memWrite,
    input  wire               memToReg,
    input  wire               regWrite,
    input  wire               isWwd,
    output cpuPkg::wordT      outputPort,
    output logic              wwdStrobe,
    output cpuPkg::wordT      numInst,
    output logic              halted
);

    cpuPkg::wordT pc, pcPlusOne, pcNext;
    cpuPkg::wordT ifIdPc;
    logic         ifIdBubble;

    cpuPkg::wordT   idExPc, idExRsData, idExRtData, idExImm;
    cpuPkg::regIdxT idExRs, idExRt, idExRd;
    cpuPkg::opcodeT idExOpcode;
    cpuPkg::funcT   idExFunc;
    logic           idExBubble, idExLink, idExIsAlu, idExAluSrc, idExMemToReg;
    logic           idExIsJumpR, idExIsBranch, idExMemRead, idExMemWrite;
    logic           idExRegWrite, idExIsWwd, idExHlt;

    cpuPkg::wordT   exMemResult, exMemStoreData;
    cpuPkg::regIdxT exMemRd;
    logic           exMemBubble, exMemMemRead, exMemMemWrite, exMemMemToReg;
    logic           exMemRegWrite, exMemIsWwd, exMemHlt;

    cpuPkg::wordT   memWbResult, memWbReadData;
    cpuPkg::regIdxT memWbRd;
    logic           memWbBubble, memWbMemToReg, memWbRegWrite, memWbIsWwd, memWbHlt;

    cpuPkg::opcodeT idOpcode;
    cpuPkg::funcT   idFunc;
    cpuPkg::regIdxT idRs, idRt, idRd;
    cpuPkg::wordT   idImm, idRsRaw, idRtRaw, idRsData, idRtData, jumpTarget;
    logic           idUseRs, idUseRt, idHlt, idRedirect;

    cpuPkg::fwdSelT fwdA, fwdB;
    cpuPkg::wordT   exRsVal, exRtVal, aluA, aluB, aluResult, branchTarget, wbValue;
    logic           bcond, branchTaken, exRedirect, loadStall, hltAhead, idExSquash;

    assign idOpcode = ifIdInstr[15:12];
    assign idRs     = ifIdInstr[11:10];
    assign idRt     = ifIdInstr[9:8];
    assign idFunc   = ifIdInstr[5:0];
    assign idHlt    = (idOpcode == `RTYPE_OP) && (idFunc == `FUNC_HLT);
    assign idRd     = (regWrite && (isJumpI || isJumpR)) ? cpuPkg::regIdxT'(2)
                    : (regDst ? ifIdInstr[7:6] : idRt);

    // ori takes its immediate unsigned
    assign idImm = (idOpcode == `ORI_OP) ? {8'h00, ifIdInstr[7:0]}
                                         : {{8{ifIdInstr[7]}}, ifIdInstr[7:0]};
    assign jumpTarget = {ifIdPc[15:12], ifIdInstr[11:0]};

    assign idUseRs = !ifIdBubble && (idOpcode != `JMP_OP) && (idOpcode != `JAL_OP);
    assign idUseRt = !ifIdBubble
                  && (((idOpcode == `RTYPE_OP) && (idFunc <= `FUNC_SHR))
                   || (idOpcode == `BNE_OP) || (idOpcode == `BEQ_OP)
                   || (idOpcode == `SWD_OP));

    // decode sees a register that is being written back in this cycle
    assign idRsData = (memWbRegWrite && (memWbRd == idRs)) ? wbValue : idRsRaw;
    assign idRtData = (memWbRegWrite && (memWbRd == idRt)) ? wbValue : idRtRaw;

    always_comb begin
        case (fwdA)
            cpuPkg::fwdMem: exRsVal = exMemResult;
            cpuPkg::fwdWb:  exRsVal = wbValue;
            default:        exRsVal = idExRsData;
        endcase
        case (fwdB)
            cpuPkg::fwdMem: exRtVal = exMemResult;
            cpuPkg::fwdWb:  exRtVal = wbValue;
            default:        exRtVal = idExRtData;
        endcase
    end

    // links write the return address through the alu
    assign aluA         = idExLink ? idExPc : exRsVal;
    assign aluB         = idExAluSrc ? idExImm : exRtVal;
    assign branchTarget = idExPc + idExImm;
    assign branchTaken  = !idExBubble && idExIsBranch && bcond;
    assign exRedirect   = branchTaken || (!idExBubble && idExIsJumpR);
    assign idRedirect   = !ifIdBubble && isJumpI;

    // nothing younger than an hlt may reach memory or writeback
    assign hltAhead   = idExHlt || exMemHlt;
    assign idExSquash = ifIdBubble || exRedirect || loadStall || hltAhead;

    assign pcPlusOne = pc + `WORD_SIZE'd1;

    always_comb begin
        if (loadStall) begin
            pcNext = pc;
        end else if (branchTaken) begin
            pcNext = branchTarget;
        end else if (exRedirect) begin
            pcNext = exRsVal;
        end else if (idRedirect) begin
            pcNext = jumpTarget;
        end else begin
            pcNext = pcPlusOne;
        end
    end

    assign wbValue   = memWbMemToReg ? memWbReadData : memWbResult;
    assign instrAddr = pc;
    assign dataAddr  = exMemResult;
    assign writeData = exMemStoreData;
    assign dataRead  = exMemMemRead;
    assign dataWrite = exMemMemWrite;

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            pc            <= '0;
            ifIdBubble    <= 1'b1;
            idExBubble    <= 1'b1;
            idExIsJumpR   <= 1'b0;
            idExIsBranch  <= 1'b0;
            idExMemRead   <= 1'b0;
            idExMemWrite  <= 1'b0;
            idExRegWrite  <= 1'b0;
            idExIsWwd     <= 1'b0;
            idExHlt       <= 1'b0;
            exMemBubble   <= 1'b1;
            exMemMemRead  <= 1'b0;
            exMemMemWrite <= 1'b0;
            exMemRegWrite <= 1'b0;
            exMemIsWwd    <= 1'b0;
            exMemHlt      <= 1'b0;
            memWbBubble   <= 1'b1;
            memWbRegWrite <= 1'b0;
            memWbIsWwd    <= 1'b0;
            memWbHlt      <= 1'b0;
            wwdStrobe     <= 1'b0;
            outputPort    <= '0;
            numInst       <= '0;
            halted        <= 1'b0;
        end else if (!halted) begin
            pc <= pcNext;
            if (!loadStall) begin
                ifIdBubble <= exRedirect || idRedirect;
            end

            idExBubble   <= idExSquash;
            idExIsJumpR  <= !idExSquash && isJumpR;
            idExIsBranch <= !idExSquash && isBranch;
            idExMemRead  <= !idExSquash && memRead;
            idExMemWrite <= !idExSquash && memWrite;
            idExRegWrite <= !idExSquash && regWrite;
            idExIsWwd    <= !idExSquash && isWwd;
            idExHlt      <= !idExSquash && idHlt;

            exMemBubble   <= idExBubble;
            exMemMemRead  <= idExMemRead;
            exMemMemWrite <= idExMemWrite;
            exMemRegWrite <= idExRegWrite;
            exMemIsWwd    <= idExIsWwd;
            exMemHlt      <= idExHlt;

            memWbBubble   <= exMemBubble;
            memWbRegWrite <= exMemRegWrite;
            memWbIsWwd    <= exMemIsWwd;
            memWbHlt      <= exMemHlt;

            wwdStrobe <= memWbIsWwd;
            if (memWbIsWwd) begin
                outputPort <= memWbResult;
            end
            if (!memWbBubble) begin
                numInst <= numInst + `WORD_SIZE'd1;
            end
            if (memWbHlt) begin
                halted <= 1'b1;
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (!halted) begin
            if (!loadStall) begin
                ifIdInstr <= instrData;
                ifIdPc    <= pcPlusOne;
            end
            idExPc       <= ifIdPc;
            idExRsData   <= idRsData;
            idExRtData   <= idRtData;
            idExImm      <= idImm;
            idExRs       <= idRs;
            idExRt       <= idRt;
            idExRd       <= idRd;
            idExOpcode   <= idOpcode;
            idExFunc     <= idFunc;
            idExLink     <= regWrite && (isJumpI || isJumpR);
            idExIsAlu    <= isAlu;
            idExAluSrc   <= aluSrc;
            idExMemToReg <= memToReg;

            exMemResult    <= aluResult;
            exMemStoreData <= exRtVal;
            exMemRd        <= idExRd;
            exMemMemToReg  <= idExMemToReg;

            memWbResult   <= exMemResult;
            memWbReadData <= readData;
            memWbRd       <= exMemRd;
            memWbMemToReg <= exMemMemToReg;
        end
    end

    regFile regFile_i (
        .Clk       (Clk),
        .arstN     (arstN),
        .rs        (idRs),
        .rt        (idRt),
        .rd        (memWbRd),
        .writeData (wbValue),
        .regWrite  (memWbRegWrite),
        .rsData    (idRsRaw),
        .rtData    (idRtRaw)
    );

    alu alu_i (
        .opcode (idExOpcode),
        .func   (idExFunc),
        .isAlu  (idExIsAlu),
        .a      (aluA),
        .b      (aluB),
        .result (aluResult),
        .bcond  (bcond)
    );

    hazardUnit hazardUnit_i (
        .idRs        (idRs),
        .idRt        (idRt),
        .idUseRs     (idUseRs),
        .idUseRt     (idUseRt),
        .exRs        (idExRs),
        .exRt        (idExRt),
        .exRd        (idExRd),
        .exMemRead   (idExMemRead),
        .memRd       (exMemRd),
        .memRegWrite (exMemRegWrite),
        .wbRd        (memWbRd),
        .wbRegWrite  (memWbRegWrite),
        .fwdA        (fwdA),
        .fwdB        (fwdB),
        .loadStall   (loadStall)
    );

endmodule

`default_nettype wire

//--- logic/hazardUnit.sv
`timescale 1ns/1ps
`default_nettype none

module hazardUnit (
    input  wire cpuPkg::regIdxT idRs,
    input  wire cpuPkg::regIdxT idRt,
    input  wire                 idUseRs,
    input  wire                 idUseRt,
    input  wire cpuPkg::regIdxT exRs,
    input  wire cpuPkg::regIdxT exRt,
    input  wire cpuPkg::regIdxT exRd,
    input  wire                 exMemRead,
    input  wire cpuPkg::regIdxT memRd,
    input  wire                 memRegWrite,
    input  wire cpuPkg::regIdxT wbRd,
    input  wire                 wbRegWrite,
    output cpuPkg::fwdSelT      fwdA,
    output cpuPkg::fwdSelT      fwdB,
    output logic                loadStall
);

    // the younger producer in EX/MEM wins over writeback
    function automatic cpuPkg::fwdSelT pickSource(input cpuPkg::regIdxT src);
        if (memRegWrite && (memRd == src)) begin
            return cpuPkg::fwdMem;
        end else if (wbRegWrite && (wbRd == src)) begin
            return cpuPkg::fwdWb;
        end
        return cpuPkg::fwdNone;
    endfunction

    always_comb begin
        fwdA = pickSource(exRs);
        fwdB = pickSource(exRt);
    end

    // a load in execute has no data until its memory stage
    assign loadStall = exMemRead
                    && ((idUseRs && (idRs == exRd)) || (idUseRt && (idRt == exRd)));

endmodule

`default_nettype wire

//--- logic/instrDecoder.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_settings.svh"

module instrDecoder (
    input  wire cpuPkg::wordT instr,
    output logic              regDst,
    output logic              isJumpI,
    output logic              isJumpR,
    output logic              isAlu,
    output logic              aluSrc,
    output logic              isBranch,
    output logic              memRead,
    output logic              memWrite,
    output logic              memToReg,
    output logic              regWrite,
    output logic              isWwd
);

    cpuPkg::opcodeT opcode;
    cpuPkg::funcT   func;
    logic           rtype;
    logic           aluFunc;

    assign opcode = instr[15:12];
    assign func   = instr[5:0];
    assign rtype  = (opcode == `RTYPE_OP);

    // arithmetic and logic functions sit below the jump and system codes
    assign aluFunc = rtype && (func <= `FUNC_SHR);

    assign regDst  = aluFunc;
    assign isAlu   = aluFunc;
    assign isJumpI = (opcode == `JMP_OP) || (opcode == `JAL_OP);
    assign isJumpR = rtype && ((func == `FUNC_JPR) || (func == `FUNC_JRL));
    assign isWwd   = rtype && (func == `FUNC_WWD);

    assign aluSrc = (opcode == `ADI_OP) || (opcode == `ORI_OP) || (opcode == `LHI_OP)
                 || (opcode == `LWD_OP) || (opcode == `SWD_OP);

    assign isBranch = (opcode == `BNE_OP) || (opcode == `BEQ_OP)
                   || (opcode == `BGZ_OP) || (opcode == `BLZ_OP);

    assign memRead  = (opcode == `LWD_OP);
    assign memWrite = (opcode == `SWD_OP);
    assign memToReg = (opcode == `LWD_OP);

    // jal and jrl link into register 2
    assign regWrite = aluFunc
                   || (opcode == `ADI_OP) || (opcode == `ORI_OP) || (opcode == `LHI_OP)
                   || (opcode == `LWD_OP) || (opcode == `JAL_OP)
                   || (rtype && (func == `FUNC_JRL));

endmodule

`default_nettype wire

//--- logic/regFile.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_settings.svh"

module regFile (
    input  wire                 Clk,
    input  wire                 arstN,
    input  wire cpuPkg::regIdxT rs,
    input  wire cpuPkg::regIdxT rt,
    input  wire cpuPkg::regIdxT rd,
    input  wire cpuPkg::wordT   writeData,
    input  wire                 regWrite,
    output cpuPkg::wordT        rsData,
    output cpuPkg::wordT        rtData
);

    cpuPkg::wordT regs [`NUM_REGS];

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (regWrite) begin
            regs[rd] <= writeData;
        end
    end

    assign rsData = regs[rs];
    assign rtData = regs[rt];

endmodule

`default_nettype wire

//--- sim/isaModel.svh
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

localparam int bodyLen  = 60;
localparam int maxSteps = 2000;

cpuPkg::wordT progMem [`DMEM_DEPTH];
int           progLen;
cpuPkg::wordT expWwd[$];
cpuPkg::wordT expStoreAddr[$];
cpuPkg::wordT expStoreData[$];
int           expRetired;
logic         modelOk;

// initial data memory contents, every address bit feeds in
function automatic cpuPkg::wordT fillWord(input int addr);
    return cpuPkg::wordT'(addr * 40503) ^ 16'h5a5a;
endfunction

function automatic cpuPkg::wordT encodeR(input int rs, input int rt, input int rd,
                                         input cpuPkg::funcT func);
    return {`RTYPE_OP, 2'(rs), 2'(rt), 2'(rd), func};
endfunction

function automatic cpuPkg::wordT encodeI(input cpuPkg::opcodeT op, input int rs,
                                         input int rt, input int imm);
    return {op, 2'(rs), 2'(rt), 8'(imm)};
endfunction

function automatic int pickReg();
    return $urandom_range(3, 0);
endfunction

task automatic emit(input cpuPkg::wordT instr);
    progMem[progLen] = instr;
    progLen++;
endtask

task automatic generateProgram();
    int kind;
    int base;
    int dst;
    int skip;
    progLen = 0;
    for (int i = 0; i < `DMEM_DEPTH; i++) begin
        progMem[i] = encodeR(0, 0, 0, `FUNC_HLT);
    end
    // call and return: jal to 2, jrl back to 1, jmp on to 3
    emit({`JAL_OP, 12'd2});
    emit({`JMP_OP, 12'd3});
    emit(encodeR(2, 0, 0, `FUNC_JRL));
    while (progLen < bodyLen) begin
        kind = $urandom_range(9, 0);
        base = pickReg();
        dst  = pickReg();
        skip = $urandom_range(3, 0);
        case (kind)
            0, 1, 2, 3: begin
                emit(encodeR(pickReg(), pickReg(), dst, cpuPkg::funcT'($urandom_range(7, 0))));
            end
            4: begin
                emit(encodeI(cpuPkg::opcodeT'($urandom_range(6, 4)), pickReg(), dst,
                             $urandom_range(255, 0)));
            end
            5: begin
                // load straight into a consumer
                emit(encodeI(`LHI_OP, 0, base, 0));
                emit(encodeI(`LWD_OP, base, dst, $urandom_range(15, 0)));
                emit(encodeR(dst, pickReg(), pickReg(), cpuPkg::funcT'($urandom_range(7, 0))));
            end
            6: begin
                emit(encodeI(`LHI_OP, 0, base, 0));
                emit(encodeI(`SWD_OP, base, pickReg(), $urandom_range(15, 0)));
            end
            7: begin
                emit(encodeI(cpuPkg::opcodeT'($urandom_range(3, 0)), pickReg(), pickReg(), skip));
            end
            8: emit({`JMP_OP, 12'(progLen + 1 + skip)});
            default: emit(encodeR(pickReg(), 0, 0, `FUNC_WWD));
        endcase
    end
    for (int r = 0; r < `NUM_REGS; r++) begin
        emit(encodeR(r, 0, 0, `FUNC_WWD));
    end
    emit(encodeR(0, 0, 0, `FUNC_HLT));
endtask

// sequential execution, one instruction at a time
task automatic runModel();
    cpuPkg::wordT   regs [`NUM_REGS];
    cpuPkg::wordT   dmem [`DMEM_DEPTH];
    cpuPkg::wordT   pc, instr, a, b, sImm, addr, nextPc;
    cpuPkg::opcodeT op;
    cpuPkg::funcT   func;
    int             rs, rt, rd, steps;
    logic           done;
    for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] = '0;
    end
    for (int i = 0; i < `DMEM_DEPTH; i++) begin
        dmem[i] = fillWord(i);
    end
    expWwd.delete();
    expStoreAddr.delete();
    expStoreData.delete();
    expRetired = 0;
    pc = '0;
    steps = 0;
    done = 1'b0;
    while (!done && steps < maxSteps) begin
        instr  = progMem[pc % `DMEM_DEPTH];
        op     = instr[15:12];
        rs     = instr[11:10];
        rt     = instr[9:8];
        rd     = instr[7:6];
        func   = instr[5:0];
        a      = regs[rs];
        b      = regs[rt];
        sImm   = {{8{instr[7]}}, instr[7:0]};
        nextPc = pc + 16'd1;
        addr   = a + sImm;
        expRetired++;
        steps++;
        case (op)
            `RTYPE_OP: begin
                case (func)
                    `FUNC_ADD: regs[rd] = a + b;
                    `FUNC_SUB: regs[rd] = a - b;
                    `FUNC_AND: regs[rd] = a & b;
                    `FUNC_ORR: regs[rd] = a | b;
                    `FUNC_NOT: regs[rd] = ~a;
                    `FUNC_TCP: regs[rd] = -a;
                    `FUNC_SHL: regs[rd] = a << 1;
                    `FUNC_SHR: regs[rd] = cpuPkg::wordT'($signed(a) >>> 1);
                    `FUNC_JPR: nextPc = a;
                    `FUNC_JRL: begin
                        regs[2] = pc + 16'd1;
                        nextPc  = a;
                    end
                    `FUNC_WWD: expWwd.push_back(a);
                    `FUNC_HLT: done = 1'b1;
                    default: ;
                endcase
            end
            `ADI_OP: regs[rt] = a + sImm;
            `ORI_OP: regs[rt] = a | {8'h00, instr[7:0]};
            `LHI_OP: regs[rt] = {instr[7:0], 8'h00};
            `LWD_OP: regs[rt] = dmem[addr % `DMEM_DEPTH];
            `SWD_OP: begin
                dmem[addr % `DMEM_DEPTH] = b;
                expStoreAddr.push_back(addr);
                expStoreData.push_back(b);
            end
            `BNE_OP: if (a != b) nextPc = pc + 16'd1 + sImm;
            `BEQ_OP: if (a == b) nextPc = pc + 16'd1 + sImm;
            `BGZ_OP: if ($signed(a) > 0) nextPc = pc + 16'd1 + sImm;
            `BLZ_OP: if ($signed(a) < 0) nextPc = pc + 16'd1 + sImm;
            `JMP_OP: nextPc = {nextPc[15:12], instr[11:0]};
            `JAL_OP: begin
                regs[2] = pc + 16'd1;
                nextPc  = {nextPc[15:12], instr[11:0]};
            end
            default: ;
        endcase
        pc = nextPc;
    end
    modelOk = done;
endtask

`endif

//--- sim/cpuCoreTb.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_settings.svh"

module cpuCoreTb;

    logic         Clk;
    logic         arstN;
    cpuPkg::wordT instrAddr, instrData, dataAddr, writeData, readData;
    cpuPkg::wordT outputPort, numInst;
    logic         dataRead, dataWrite, wwdStrobe, halted;

    cpuPkg::wordT dataMem [`DMEM_DEPTH];
    int           wwdIdx;
    int           storeIdx;
    int           watchdogCycles = 0;

    `include "isaModel.svh"

    cpuCore cpuCore_i (
        .Clk        (Clk),
        .arstN      (arstN),
        .instrAddr  (instrAddr),
        .instrData  (instrData),
        .dataAddr   (dataAddr),
        .writeData  (writeData),
        .dataRead   (dataRead),
        .dataWrite  (dataWrite),
        .readData   (readData),
        .outputPort (outputPort),
        .wwdStrobe  (wwdStrobe),
        .numInst    (numInst),
        .halted     (halted)
    );

    always #10 Clk = ~Clk;

    // both memories answer within the cycle
    assign instrData = progMem[instrAddr % `DMEM_DEPTH];
    // data comes back only while a load is strobed
    assign readData  = dataRead ? dataMem[dataAddr % `DMEM_DEPTH] : 'x;

    always @(posedge Clk) begin
        if (dataWrite) begin
            dataMem[dataAddr % `DMEM_DEPTH] <= writeData;
        end
    end

    task automatic stopOnFailure();
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic expectValue(input string name, input cpuPkg::wordT expected,
                               input cpuPkg::wordT actual);
        assert (actual == expected) else begin
            $display("ERR %s expected %h got %h", name, expected, actual);
            stopOnFailure();
        end
    endtask

    // outputs are sampled half a cycle after they change
    always @(negedge Clk) begin
        if (arstN && wwdStrobe) begin
            assert (wwdIdx < expWwd.size()) else begin
                $display("wwd output seen after all %0d expected values", expWwd.size());
                stopOnFailure();
            end
            expectValue("outputPort", expWwd[wwdIdx], outputPort);
            wwdIdx++;
        end
        if (arstN && dataWrite) begin
            assert (storeIdx < expStoreAddr.size()) else begin
                $display("store seen after all %0d expected stores", expStoreAddr.size());
                stopOnFailure();
            end
            expectValue("dataAddr", expStoreAddr[storeIdx], dataAddr);
            expectValue("writeData", expStoreData[storeIdx], writeData);
            storeIdx++;
        end
    end

    task automatic checkResetState();
        @(negedge Clk);
        expectValue("halted", '0, halted);
        expectValue("wwdStrobe", '0, wwdStrobe);
        expectValue("dataRead", '0, dataRead);
        expectValue("dataWrite", '0, dataWrite);
        expectValue("outputPort", '0, outputPort);
        expectValue("numInst", '0, numInst);
        expectValue("instrAddr", '0, instrAddr);
    endtask

    // five cycles of reset while the data memory is refilled
    task automatic resetCore();
        @(posedge Clk);
        #2;
        arstN = 1'b0;
        for (int i = 0; i < `DMEM_DEPTH; i++) begin
            dataMem[i] = fillWord(i);
        end
        wwdIdx   = 0;
        storeIdx = 0;
        repeat (4) @(posedge Clk);
        checkResetState();
        @(posedge Clk);
        #2;
        arstN = 1'b1;
        checkResetState();
    endtask

    task automatic finishRun();
        while (!halted) begin
            @(negedge Clk);
        end
        expectValue("numInst", cpuPkg::wordT'(expRetired), numInst);
        assert (wwdIdx == expWwd.size()) else begin
            $display("saw %0d wwd outputs, model has %0d", wwdIdx, expWwd.size());
            stopOnFailure();
        end
        assert (storeIdx == expStoreAddr.size()) else begin
            $display("saw %0d stores, model has %0d", storeIdx, expStoreAddr.size());
            stopOnFailure();
        end
        repeat (10) begin
            @(negedge Clk);
            expectValue("halted", 1'b1, halted);
            expectValue("wwdStrobe", '0, wwdStrobe);
            expectValue("dataRead", '0, dataRead);
            expectValue("dataWrite", '0, dataWrite);
            expectValue("numInst", cpuPkg::wordT'(expRetired), numInst);
        end
    endtask

    initial begin
        Clk      = 1'b0;
        arstN    = 1'b0;
        wwdIdx   = 0;
        storeIdx = 0;
        void'($urandom(53));
        generateProgram();
        runModel();
        assert (modelOk) else begin
            $display("model did not reach hlt within %0d steps", maxSteps);
            stopOnFailure();
        end
        // three runs of 20 cycles per instruction plus 200 each
        watchdogCycles = 3 * (20 * progLen + 200);

        resetCore();
        finishRun();

        // second run is cut short by a reset halfway through
        resetCore();
        repeat (progLen / 2) @(negedge Clk);

        resetCore();
        finishRun();

        $display("STATUS: PASS");
        $finish;
    end

    initial begin
        wait (watchdogCycles > 0);
        repeat (watchdogCycles) @(posedge Clk);
        $display("timeout, programs did not finish within %0d cycles", watchdogCycles);
        stopOnFailure();
    end

endmodule

`default_nettype wire
